/* list.f */
+incdir+.
alu_pkg.sv
adder.sv
comparison_unit.sv
logic_unit.sv
shifter.sv
alu.sv
alu_apb_ctrl.sv
alu_subsys.sv
tb_alu_subsys.sv

/* tb_alu_subsys.sv */
/*
 * Directed testbench for the APB ALU subsystem, with a reference model,
 * a cycle-count timeout and a closing summary
 */

`timescale 1ns/10ps

`include "alu_defs.svh"

module tb_alu_subsys;

    localparam int MAX_CYCLES = 3000;   // about twice the summed length of all tests

    logic              clk;
    logic              arst_n;
    alu_pkg::apb_req_t req;
    alu_pkg::apb_rsp_t rsp;
    int                pass_cnt;
    int                fail_cnt;
    int                cycle_cnt;
    integer            seed;
    logic [31:0]       last_res;
    logic [31:0]       last_cmp;

    alu_subsys u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .apb_req (req),
        .apb_rsp (rsp)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] ref_comp(logic [3:0] op, logic [31:0] a, logic [31:0] b);
        logic lt_s;
        lt_s = (a[31] != b[31]) ? a[31] : (a < b);   // differing signs decide on their own
        case (op)
            alu_pkg::EQ:  return {31'b0, a == b};
            alu_pkg::NE:  return {31'b0, a != b};
            alu_pkg::LT:  return {31'b0, lt_s};
            alu_pkg::GE:  return {31'b0, !lt_s};
            alu_pkg::LTU: return {31'b0, a < b};
            alu_pkg::GEU: return {31'b0, !(a < b)};
            default:      return 32'b0;
        endcase
    endfunction

    function automatic logic [31:0] ref_result(logic [3:0] op, logic [31:0] add_a,
                                               logic [31:0] a, logic [31:0] b,
                                               logic [31:0] cmp);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            alu_pkg::ADD: return add_a + b;
            alu_pkg::SUB: return add_a - b;
            alu_pkg::AND: return a & b;
            alu_pkg::OR:  return a | b;
            alu_pkg::XOR: return a ^ b;
            alu_pkg::SLL: return a << sh;
            alu_pkg::SRL: return a >> sh;
            alu_pkg::SRA: return (a >> sh) | (a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'b0);
            default:      return cmp;   // compare ops return the compare outcome
        endcase
    endfunction

    task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
        assert (act === exp) pass_cnt++;
        else begin
            $display("mismatch at %0t: %s expected 0x%08h actual 0x%08h", $time, name, exp, act);
            fail_cnt++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        assert (cond === 1'b1) pass_cnt++;
        else begin
            $display("error at %0t: %s", $time, what);
            fail_cnt++;
        end
    endtask

    task automatic apb_write(logic [7:0] addr, logic [31:0] data, output logic err);
        @(posedge clk);
        req.psel    <= 1'b1;
        req.penable <= 1'b0;
        req.pwrite  <= 1'b1;
        req.paddr   <= addr;
        req.pwdata  <= data;
        @(posedge clk);
        req.penable <= 1'b1;
        @(negedge clk);
        err = rsp.pslverr;
        check_true(rsp.pready, "pready low in a write access phase");
    endtask

    task automatic apb_read(logic [7:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        req.psel    <= 1'b1;
        req.penable <= 1'b0;
        req.pwrite  <= 1'b0;
        req.paddr   <= addr;
        @(posedge clk);
        req.penable <= 1'b1;
        @(negedge clk);
        data = rsp.prdata;
        err  = rsp.pslverr;
        check_true(rsp.pready, "pready low in a read access phase");
    endtask

    task automatic bus_idle();
        @(posedge clk);
        req.psel    <= 1'b0;
        req.penable <= 1'b0;
        req.pwrite  <= 1'b0;
    endtask

    task automatic write_reg(logic [7:0] addr, logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        check_true(!err, $sformatf("unexpected pslverr on a write to 0x%02h", addr));
    endtask

    task automatic read_check(string name, logic [7:0] addr, logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check_val(name, exp, data);
        check_true(!err, $sformatf("unexpected pslverr on a read of %s", name));
    endtask

    task automatic wait_done();
        logic [31:0] status;
        logic        err;
        int          tries;
        status = '0;
        tries  = 0;
        while (status[0] !== 1'b1 && tries < 4) begin
            apb_read(`REG_STATUS, status, err);
            tries++;
        end
        check_true(status[0], "STATUS done never set after the CTRL write");
    endtask

    task automatic run_op(logic [3:0] op, logic alt, logic pcs, logic [31:0] o1,
                          logic [31:0] o2, logic [31:0] o3, logic [31:0] o4,
                          logic [11:0] pc);
        logic [31:0] exp_cmp;
        logic [31:0] exp_res;
        write_reg(`REG_OPD1, o1);
        write_reg(`REG_OPD2, o2);
        write_reg(`REG_OPD3, o3);
        write_reg(`REG_OPD4, o4);
        write_reg(`REG_PC, {20'b0, pc});
        write_reg(`REG_CTRL, {26'b0, op, alt, pcs});
        wait_done();
        exp_cmp = ref_comp(op, alt ? o3 : o1, alt ? o4 : o2);
        exp_res = ref_result(op, pcs ? {20'b0, pc} : o1, o1, o2, exp_cmp);
        read_check("RESULT", `REG_RESULT, exp_res);
        read_check("COMP", `REG_COMP, exp_cmp);
        last_res = exp_res;
        last_cmp = exp_cmp;
    endtask

    task automatic end_test(string name, int fails_before);
        bus_idle();
        $display("test %s finished with %0d failures", name, fail_cnt - fails_before);
    endtask

    task automatic test_reset();
        int f0;
        f0 = fail_cnt;
        read_check("RESULT", `REG_RESULT, 32'h0);
        read_check("COMP", `REG_COMP, 32'h0);
        read_check("STATUS", `REG_STATUS, 32'h0);
        end_test("reset", f0);
    endtask

    task automatic test_adder();
        int f0;
        f0 = fail_cnt;
        run_op(alu_pkg::ADD, 1'b0, 1'b0, 32'd1200, 32'd345, 32'd0, 32'd0, 12'h0);
        run_op(alu_pkg::ADD, 1'b0, 1'b0, 32'hFFFF_FFFF, 32'd2, 32'd0, 32'd0, 12'h0);
        run_op(alu_pkg::SUB, 1'b0, 1'b0, 32'd5, 32'd7, 32'd0, 32'd0, 12'h0);
        run_op(alu_pkg::ADD, 1'b0, 1'b1, 32'hDEAD_0000, 32'd16, 32'd0, 32'd0, 12'hFF0);
        // same operands, now subtract, and watch done drop in the launch cycle
        write_reg(`REG_CTRL, {26'b0, alu_pkg::SUB, 2'b00});
        bus_idle();
        @(negedge clk);
        check_true(u_dut.u_alu_apb_ctrl.done === 1'b0, "done did not clear on the CTRL write");
        wait_done();
        read_check("RESULT", `REG_RESULT, 32'hDEAD_0000 - 32'd16);
        end_test("adder", f0);
    endtask

    task automatic test_logic_shift();
        int          f0;
        logic [31:0] b;
        f0 = fail_cnt;
        run_op(alu_pkg::AND, 1'b0, 1'b0, 32'hF0F0_1234, 32'h0FF0_FF00, 32'd0, 32'd0, 12'h0);
        run_op(alu_pkg::OR, 1'b0, 1'b0, 32'hF0F0_1234, 32'h0FF0_FF00, 32'd0, 32'd0, 12'h0);
        run_op(alu_pkg::XOR, 1'b0, 1'b0, 32'hF0F0_1234, 32'h0FF0_FF00, 32'd0, 32'd0, 12'h0);
        for (int i = 0; i < 32; i++) begin
            if (i == 0 || i == 1 || i == 31) begin
                b = 32'hABCD_EF00 | i;   // upper bits must not affect the shift amount
                run_op(alu_pkg::SLL, 1'b0, 1'b0, 32'h8765_4321, b, 32'd0, 32'd0, 12'h0);
                run_op(alu_pkg::SRL, 1'b0, 1'b0, 32'h8765_4321, b, 32'd0, 32'd0, 12'h0);
                run_op(alu_pkg::SRA, 1'b0, 1'b0, 32'h8765_4321, b, 32'd0, 32'd0, 12'h0);
            end
        end
        end_test("logic_shift", f0);
    endtask

    task automatic test_compare();
        int f0;
        f0 = fail_cnt;
        for (int op = alu_pkg::EQ; op <= alu_pkg::GEU; op++) begin
            run_op(4'(op), 1'b0, 1'b0, 32'h8000_0000, 32'h7FFF_FFFF, 32'd0, 32'd0, 12'h0);
            run_op(4'(op), 1'b0, 1'b0, 32'h0000_0005, 32'h0000_0005, 32'd0, 32'd0, 12'h0);
        end
        // opd1/opd2 give the opposite answer to opd3/opd4
        run_op(alu_pkg::EQ, 1'b1, 1'b0, 32'd5, 32'd5, 32'd1, 32'd2, 12'h0);
        run_op(alu_pkg::LT, 1'b1, 1'b0, 32'd3, 32'd1, 32'hFFFF_FFFF, 32'd0, 12'h0);
        end_test("compare", f0);
    endtask

    task automatic test_bus_errors();
        int          f0;
        logic [31:0] data;
        logic        err;
        f0 = fail_cnt;
        apb_read(8'h24, data, err);
        check_true(err, "no pslverr on a read of unmapped address 0x24");
        apb_write(`REG_RESULT, 32'hDEAD_BEEF, err);
        check_true(err, "no pslverr on a write to RESULT");
        read_check("RESULT", `REG_RESULT, last_res);
        apb_write(`REG_CTRL, {26'b0, 4'd14, 2'b00}, err);
        check_true(err, "no pslverr on a CTRL write with illegal op code 14");
        read_check("RESULT", `REG_RESULT, last_res);
        read_check("COMP", `REG_COMP, last_cmp);
        read_check("STATUS", `REG_STATUS, 32'h1);
        end_test("bus_errors", f0);
    endtask

    task automatic test_random();
        int          f0;
        logic [3:0]  op;
        logic [31:0] o [4];
        f0 = fail_cnt;
        for (int n = 0; n < 40; n++) begin
            op = 4'($unsigned($random(seed)) % 14);
            foreach (o[i]) o[i] = $random(seed);
            run_op(op, o[2][0], o[3][0], o[0], o[1], o[2], o[3], o[1][27:16]);
        end
        end_test("random", f0);
    endtask

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        req       = '0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        cycle_cnt = 0;
        seed      = 27749;
        last_res  = '0;
        last_cmp  = '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        test_reset();
        test_adder();
        test_logic_shift();
        test_compare();
        test_bus_errors();
        test_random();
        $display("checks passed %0d, checks failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* alu_subsys.sv */
/*
 * ALU subsystem top, the APB control block wired to the ALU
 */

`timescale 1ns/10ps

`include "alu_defs.svh"

module alu_subsys (
    input  logic              clk,
    input  logic              arst_n,
    input  alu_pkg::apb_req_t apb_req,
    output alu_pkg::apb_rsp_t apb_rsp
);

    alu_pkg::alu_opd_t     opd;
    alu_pkg::alu_ctrl_t    ctrl;
    logic                  launch;
    logic [`ALU_OPD_W-1:0] alu_result;
    logic [`ALU_OPD_W-1:0] comp_result;

    alu_apb_ctrl u_alu_apb_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .apb_req     (apb_req),
        .alu_result  (alu_result),
        .comp_result (comp_result),
        .apb_rsp     (apb_rsp),
        .opd         (opd),
        .ctrl        (ctrl),
        .launch      (launch)
    );

    alu u_alu (
        .clk         (clk),
        .arst_n      (arst_n),
        .opd         (opd),
        .ctrl        (ctrl),
        .launch      (launch),
        .alu_result  (alu_result),
        .comp_result (comp_result)
    );

endmodule

/* alu_apb_ctrl.sv */
/*
 * APB slave for the ALU: operand, pc and control registers, operation
 * launch, result capture with a done flag, and the error response
 */

`timescale 1ns/10ps

`include "alu_defs.svh"

module alu_apb_ctrl (
    input  logic                  clk,
    input  logic                  arst_n,
    input  alu_pkg::apb_req_t     apb_req,
    input  logic [`ALU_OPD_W-1:0] alu_result,
    input  logic [`ALU_OPD_W-1:0] comp_result,
    output alu_pkg::apb_rsp_t     apb_rsp,
    output alu_pkg::alu_opd_t     opd,
    output alu_pkg::alu_ctrl_t    ctrl,
    output logic                  launch
);

    localparam int CTRL_W = $bits(alu_pkg::alu_ctrl_t);

    alu_pkg::alu_ctrl_t    ctrl_new;
    logic                  access;
    logic                  addr_hit;
    logic                  addr_ro;
    logic                  ctrl_bad;
    logic                  slverr;
    logic                  wr_ok;
    logic                  ctrl_wr;
    logic                  done;
    logic [`ALU_OPD_W-1:0] result_q;
    logic [`ALU_OPD_W-1:0] comp_q;
    logic [31:0]           rd_data;

    assign access   = apb_req.psel & apb_req.penable;
    assign ctrl_new = alu_pkg::alu_ctrl_t'(apb_req.pwdata[CTRL_W-1:0]);
    assign ctrl_bad = (apb_req.paddr == `REG_CTRL) && !alu_pkg::op_legal(ctrl_new.op);

    // address decode and read mux
    always_comb begin
        addr_hit = 1'b1;
        addr_ro  = 1'b0;
        rd_data  = '0;
        case (apb_req.paddr)
            `REG_OPD1: rd_data = opd.opd1;
            `REG_OPD2: rd_data = opd.opd2;
            `REG_OPD3: rd_data = opd.opd3;
            `REG_OPD4: rd_data = opd.opd4;
            `REG_PC:   rd_data = {{(32-`ALU_PC_W){1'b0}}, opd.pc};
            `REG_CTRL: rd_data = {{(32-CTRL_W){1'b0}}, ctrl};
            `REG_RESULT: begin
                rd_data = result_q;
                addr_ro = 1'b1;
            end
            `REG_COMP: begin
                rd_data = comp_q;
                addr_ro = 1'b1;
            end
            `REG_STATUS: begin
                rd_data = {31'b0, done};
                addr_ro = 1'b1;
            end
            default: addr_hit = 1'b0;
        endcase
    end

    assign slverr  = access & (!addr_hit | (apb_req.pwrite & (addr_ro | ctrl_bad)));
    assign wr_ok   = access & apb_req.pwrite & !slverr;   // a faulty write changes nothing
    assign ctrl_wr = wr_ok && (apb_req.paddr == `REG_CTRL);

    always_comb begin
        apb_rsp.prdata  = (access && !apb_req.pwrite) ? rd_data : '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = slverr;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opd      <= '0;
            ctrl     <= '0;
            launch   <= 1'b0;
            result_q <= '0;
            comp_q   <= '0;
            done     <= 1'b0;
        end else begin
            launch <= ctrl_wr;
            if (launch) begin
                result_q <= alu_result;   // ALU output settles within the launch cycle
                comp_q   <= comp_result;
                done     <= 1'b1;
            end
            if (wr_ok) begin
                case (apb_req.paddr)
                    `REG_OPD1: opd.opd1 <= apb_req.pwdata;
                    `REG_OPD2: opd.opd2 <= apb_req.pwdata;
                    `REG_OPD3: opd.opd3 <= apb_req.pwdata;
                    `REG_OPD4: opd.opd4 <= apb_req.pwdata;
                    `REG_PC:   opd.pc   <= apb_req.pwdata[`ALU_PC_W-1:0];
                    `REG_CTRL: begin
                        ctrl <= ctrl_new;
                        done <= 1'b0;   // a new op overrides a capture in the same cycle
                    end
                    default: ;
                endcase
            end
        end
    end

    a_penable_needs_psel: assert property (@(posedge clk) disable iff (!arst_n)
        apb_req.penable |-> apb_req.psel);

    a_paddr_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (apb_req.psel && !apb_req.penable) ##1 (apb_req.psel && apb_req.penable)
        |-> $stable(apb_req.paddr));

endmodule

/* alu.sv */
/*
 * Integer ALU: operand selection, adder, comparison, logic and shift
 * units, and the result mux
 */

`timescale 1ns/10ps

`include "alu_defs.svh"

module alu (
    input  logic                  clk,
    input  logic                  arst_n,
    input  alu_pkg::alu_opd_t     opd,
    input  alu_pkg::alu_ctrl_t    ctrl,
    input  logic                  launch,
    output logic [`ALU_OPD_W-1:0] alu_result,
    output logic [`ALU_OPD_W-1:0] comp_result
);

    logic [`ALU_OPD_W-1:0] pc_ext;
    logic [`ALU_OPD_W-1:0] adder_a;
    logic [`ALU_OPD_W-1:0] cu_a;
    logic [`ALU_OPD_W-1:0] cu_b;
    logic [`ALU_OPD_W-1:0] sum;
    logic [`ALU_OPD_W-1:0] logic_result;
    logic [`ALU_OPD_W-1:0] shift_result;
    logic [1:0]            res_sel;

    assign pc_ext  = {{(`ALU_OPD_W-`ALU_PC_W){1'b0}}, opd.pc};
    assign adder_a = ctrl.pc_src ? pc_ext : opd.opd1;
    assign cu_a    = ctrl.cmp_alt_src ? opd.opd3 : opd.opd1;
    assign cu_b    = ctrl.cmp_alt_src ? opd.opd4 : opd.opd2;

    adder u_adder (
        .a   (adder_a),
        .b   (opd.opd2),
        .sub (ctrl.op == alu_pkg::SUB),
        .sum (sum)
    );

    comparison_unit u_comparison_unit (
        .a           (cu_a),
        .b           (cu_b),
        .op          (ctrl.op),
        .comp_result (comp_result)
    );

    logic_unit u_logic_unit (
        .a            (opd.opd1),
        .b            (opd.opd2),
        .op           (ctrl.op),
        .logic_result (logic_result)
    );

    shifter u_shifter (
        .a            (opd.opd1),
        .b            (opd.opd2),
        .op           (ctrl.op),
        .shift_result (shift_result)
    );

    // result group follows from the op code
    always_comb begin
        case (ctrl.op)
            alu_pkg::AND, alu_pkg::OR, alu_pkg::XOR:                       res_sel = 2'd1;
            alu_pkg::SLL, alu_pkg::SRL, alu_pkg::SRA:                      res_sel = 2'd2;
            alu_pkg::EQ, alu_pkg::NE, alu_pkg::LT, alu_pkg::GE,
            alu_pkg::LTU, alu_pkg::GEU:                                    res_sel = 2'd3;
            default:                                                       res_sel = 2'd0;
        endcase
    end

    always_comb begin
        case (res_sel)
            2'd1:    alu_result = logic_result;
            2'd2:    alu_result = shift_result;
            2'd3:    alu_result = comp_result;
            default: alu_result = sum;
        endcase
    end

    // the control block must only ever launch a legal op
    a_launch_op_legal: assert property (@(posedge clk) disable iff (!arst_n)
        launch |-> alu_pkg::op_legal(ctrl.op));

endmodule

/* shifter.sv */
/*
 * Shifter, logical left, logical right and arithmetic right shifts
 * by the low bits of the second operand
 */

`timescale 1ns/10ps

`include "alu_defs.svh"

module shifter (
    input  logic [`ALU_OPD_W-1:0] a,
    input  logic [`ALU_OPD_W-1:0] b,
    input  alu_pkg::alu_op_e      op,
    output logic [`ALU_OPD_W-1:0] shift_result
);

    localparam int SHAMT_W = $clog2(`ALU_OPD_W);

    logic [SHAMT_W-1:0] shamt;

    assign shamt = b[SHAMT_W-1:0];   // upper bits of b play no part

    always_comb begin
        case (op)
            alu_pkg::SLL: begin
                shift_result = a << shamt;
            end
            alu_pkg::SRL: begin
                shift_result = a >> shamt;
            end
            alu_pkg::SRA: begin
                shift_result = $unsigned($signed(a) >>> shamt);   // fills with the sign bit
            end
            default: begin
                shift_result = '0;
            end
        endcase
    end

endmodule

/* logic_unit.sv */
/*
 * Logic unit, bitwise AND, OR and XOR
 */

`timescale 1ns/10ps

`include "alu_defs.svh"

module logic_unit (
    input  logic [`ALU_OPD_W-1:0] a,
    input  logic [`ALU_OPD_W-1:0] b,
    input  alu_pkg::alu_op_e      op,
    output logic [`ALU_OPD_W-1:0] logic_result
);

    always_comb begin
        case (op)
            alu_pkg::AND: begin
                logic_result = a & b;
            end
            alu_pkg::OR: begin
                logic_result = a | b;
            end
            alu_pkg::XOR: begin
                logic_result = a ^ b;
            end
            default: begin
                logic_result = '0;
            end
        endcase
    end

endmodule

/* comparison_unit.sv */
/*
 * Comparison unit, equality and signed/unsigned ordering tests
 * with a zero-extended one-bit outcome
 */

`timescale 1ns/10ps

`include "alu_defs.svh"

module comparison_unit (
    input  logic [`ALU_OPD_W-1:0] a,
    input  logic [`ALU_OPD_W-1:0] b,
    input  alu_pkg::alu_op_e      op,
    output logic [`ALU_OPD_W-1:0] comp_result
);

    logic hit;

    always_comb begin
        case (op)
            alu_pkg::EQ: begin
                hit = (a == b);
            end
            alu_pkg::NE: begin
                hit = (a != b);
            end
            alu_pkg::LT: begin
                hit = ($signed(a) < $signed(b));
            end
            alu_pkg::GE: begin
                hit = ($signed(a) >= $signed(b));
            end
            alu_pkg::LTU: begin
                hit = (a < b);
            end
            alu_pkg::GEU: begin
                hit = (a >= b);
            end
            default: begin
                hit = 1'b0;   // not a compare, so nothing to report
            end
        endcase
    end

    assign comp_result = {{(`ALU_OPD_W-1){1'b0}}, hit};

endmodule

/* adder.sv */
/*
 * Adder/subtractor, modular add or subtract of two operands
 */

`timescale 1ns/10ps

`include "alu_defs.svh"

module adder (
    input  logic [`ALU_OPD_W-1:0] a,
    input  logic [`ALU_OPD_W-1:0] b,
    input  logic                  sub,
    output logic [`ALU_OPD_W-1:0] sum
);

    logic [`ALU_OPD_W-1:0] b_eff;
    logic [`ALU_OPD_W-1:0] carry_in;

    // two's complement subtract uses the inverted operand plus one
    assign b_eff    = b ^ {`ALU_OPD_W{sub}};
    assign carry_in = {{(`ALU_OPD_W-1){1'b0}}, sub};

    assign sum = a + b_eff + carry_in;   // carry out is dropped

endmodule

/* alu_pkg.sv */
/*
 * ALU subsystem types: operation codes, operand and control bundles,
 * and the APB request and response
 */

`include "alu_defs.svh"

package alu_pkg;

    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        SLL = 4'd5,
        SRL = 4'd6,
        SRA = 4'd7,
        EQ  = 4'd8,
        NE  = 4'd9,
        LT  = 4'd10,
        GE  = 4'd11,
        LTU = 4'd12,
        GEU = 4'd13
    } alu_op_e;   // codes 14 and 15 are illegal

    typedef struct packed {
        logic [`ALU_OPD_W-1:0] opd1;
        logic [`ALU_OPD_W-1:0] opd2;
        logic [`ALU_OPD_W-1:0] opd3;
        logic [`ALU_OPD_W-1:0] opd4;
        logic [`ALU_PC_W-1:0]  pc;
    } alu_opd_t;

    // also the layout of CTRL bits [5:0]
    typedef struct packed {
        alu_op_e op;
        logic    cmp_alt_src;   // compare opd3/opd4 instead of opd1/opd2
        logic    pc_src;        // adder takes the pc instead of opd1
    } alu_ctrl_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_ADDR_W-1:0] paddr;
        logic [31:0]            pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    function automatic logic op_legal(alu_op_e op);
        return op inside {ADD, SUB, AND, OR, XOR, SLL, SRL, SRA,
                          EQ, NE, LT, GE, LTU, GEU};
    endfunction

endpackage

/* alu_defs.svh */
/*
 * ALU subsystem widths and APB register map
 */

`ifndef ALU_DEFS_SVH
`define ALU_DEFS_SVH

`define ALU_OPD_W   32
`define ALU_PC_W    12
`define APB_ADDR_W  8

// operand and program counter registers, read/write
`define REG_OPD1    8'h00
`define REG_OPD2    8'h04
`define REG_OPD3    8'h08
`define REG_OPD4    8'h0C
`define REG_PC      8'h10
`define REG_CTRL    8'h14   // a write here starts one operation

`define REG_RESULT  8'h18   // read only
`define REG_COMP    8'h1C   // read only
`define REG_STATUS  8'h20   // read only, bit 0 is done

`endif
